// ==== vec_dispatcher.f ====
vec_dispatch_pkg.sv
dispatch_if.sv
insn_decode.sv
vcfg_exec.sv
resp_issue.sv
vec_dispatcher.sv
tb_clkgen.sv
tb_checker.sv
tb_vec_dispatcher.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_vec_dispatcher
FILELIST  := vec_dispatcher.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_vec_dispatcher.sv ====
/* Testbench top for the vector dispatcher
   Directed configuration, CSR and issue cases, then a random mix */
`timescale 1ns/100ps
`default_nettype none

module tb_vec_dispatcher;

  localparam int unsigned VLEN = 256;
  localparam int TIMEOUT = 64;
  localparam logic [11:0] A_VSTART = 12'h008;
  localparam logic [11:0] A_VL     = 12'hC20;
  localparam logic [11:0] A_VTYPE  = 12'hC21;
  localparam logic [11:0] A_VLENB  = 12'hC22;

  logic                      clk;
  logic                      rst_n;
  logic                      req_valid;
  logic                      req_ready;
  logic [31:0]               req_insn;
  logic [31:0]               req_rs1;
  logic [31:0]               req_rs2;
  logic                      resp_valid;
  logic                      resp_ready;
  logic [31:0]               resp_result;
  logic                      resp_error;
  logic                      issue_valid;
  logic                      issue_ready;
  vec_dispatch_pkg::vec_op_e issue_op;
  logic [4:0]                issue_vd;
  logic [4:0]                issue_vs1;
  logic [4:0]                issue_vs2;
  logic                      issue_vm;
  logic [15:0]               issue_vl;
  logic [15:0]               issue_vstart;
  vec_dispatch_pkg::vew_e    issue_vsew;
  logic [51:0]               issue_bits;
  int                        chk_errors;
  int                        chk_count;
  int                        pending;
  int                        stim_errors;
  int                        waited;
  integer                    seed;
  logic                      rand_ready;
  logic [31:0]               last_result;
  logic                      last_error;
  logic [31:0]               rnd;
  logic [31:0]               r2;
  logic [31:0]               r3;
  logic [7:0]                bad_vt [3] = '{8'b0010_0000, 8'b0000_0100, 8'b0001_1111};
  logic [11:0]               csr_addrs [4] = '{A_VSTART, A_VL, A_VTYPE, A_VLENB};

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vec_dispatcher #(
    .VLEN (VLEN)
  ) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_insn_i     (req_insn),
    .req_rs1_i      (req_rs1),
    .req_rs2_i      (req_rs2),
    .resp_valid_o   (resp_valid),
    .resp_ready_i   (resp_ready),
    .resp_result_o  (resp_result),
    .resp_error_o   (resp_error),
    .issue_valid_o  (issue_valid),
    .issue_ready_i  (issue_ready),
    .issue_op_o     (issue_op),
    .issue_vd_o     (issue_vd),
    .issue_vs1_o    (issue_vs1),
    .issue_vs2_o    (issue_vs2),
    .issue_vm_o     (issue_vm),
    .issue_vl_o     (issue_vl),
    .issue_vstart_o (issue_vstart),
    .issue_vsew_o   (issue_vsew)
  );

  assign issue_bits = {issue_op, issue_vd, issue_vs1, issue_vs2, issue_vm, issue_vl,
                       issue_vstart, issue_vsew};

  tb_checker #(
    .VLEN (VLEN)
  ) u_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .req_insn_i    (req_insn),
    .req_rs1_i     (req_rs1),
    .req_rs2_i     (req_rs2),
    .resp_valid_i  (resp_valid),
    .resp_ready_i  (resp_ready),
    .resp_result_i (resp_result),
    .resp_error_i  (resp_error),
    .issue_valid_i (issue_valid),
    .issue_ready_i (issue_ready),
    .issue_bits_i  (issue_bits),
    .err_count_o   (chk_errors),
    .check_count_o (chk_count),
    .pending_o     (pending)
  );

  function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [7:0] vt);
    return {1'b0, 3'b000, vt, rs1, 3'b111, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {7'h40, rs2, rs1, 3'b111, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vadd(input logic [4:0] vd, input logic [4:0] vs1,
                                           input logic [4:0] vs2, input logic vm);
    return {6'd0, vm, vs2, vs1, 3'b000, vd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [11:0] addr, input logic [2:0] f3,
                                          input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, f3, rd, 7'h73};
  endfunction

  // Advance to just after the next rising edge and redraw readies if enabled
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #1;
    if (rand_ready) begin
      r           = $random(seed);
      issue_ready = r[0];
      resp_ready  = r[1] | r[2];
    end
  endtask

  task automatic send_req(input logic [31:0] insn, input logic [31:0] rs1,
                          input logic [31:0] rs2);
    int n;
    req_valid = 1'b1;
    req_insn  = insn;
    req_rs1   = rs1;
    req_rs2   = rs2;
    n         = 0;
    @(negedge clk);
    while (!req_ready && n < TIMEOUT) begin
      next_cycle();
      @(negedge clk);
      n++;
    end
    if (!req_ready) begin
      $display("Timeout: request %h was not accepted within %0d cycles", insn, TIMEOUT);
      stim_errors++;
    end else begin
      last_result = resp_result;
      last_error  = resp_error;
    end
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic expect_word(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got != exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      stim_errors++;
    end
  endtask

  initial begin
    req_valid   = 1'b0;
    req_insn    = 32'd0;
    req_rs1     = 32'd0;
    req_rs2     = 32'd0;
    resp_ready  = 1'b1;
    issue_ready = 1'b1;
    rand_ready  = 1'b0;
    stim_errors = 0;
    seed        = 32'hb912;
    waited      = 0;
    while (!rst_n && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    #1;
    if (!rst_n) begin
      $display("Timeout: reset was never released");
      stim_errors++;
    end
    expect_word({31'd0, issue_valid}, 32'd0, "issue valid after reset");

    // Reset values
    send_req(enc_csr(A_VTYPE, 3'b010, 5'd0, 5'd3), 32'd0, 32'd0);
    expect_word(last_result, 32'h8000_0000, "vtype after reset");
    send_req(enc_csr(A_VL, 3'b010, 5'd0, 5'd3), 32'd0, 32'd0);
    expect_word(last_result, 32'd0, "vl after reset");
    send_req(enc_csr(A_VLENB, 3'b110, 5'd0, 5'd3), 32'd0, 32'd0);
    expect_word(last_result, 32'd32, "vlenb");

    // Every SEW and LMUL with short and long AVL and read-back
    for (int s = 0; s < 4; s++) begin
      for (int l = -3; l < 4; l++) begin
        send_req(enc_vsetvli(5'd1, 5'd2, {2'b11, 3'(s), 3'(l)}), 32'd5, 32'd0);
        send_req(enc_vsetvl(5'd1, 5'd2, 5'd3), 32'd1000, {24'd0, 2'b00, 3'(s), 3'(l)});
        send_req(enc_csr(A_VTYPE, 3'b010, 5'd0, 5'd3), 32'd0, 32'd0);
        send_req(enc_csr(A_VL, 3'b010, 5'd0, 5'd3), 32'd0, 32'd0);
      end
    end
    // x0 source with rd set takes VLMAX of e32 m2
    send_req(enc_vsetvli(5'd1, 5'd0, 8'b0001_0001), 32'd3, 32'd0);
    expect_word(last_result, 32'd16, "vl for rs1 x0, rd x1");
    // x0 source and x0 rd keep vl although e8 m1 has VLMAX 32
    send_req(enc_vsetvli(5'd0, 5'd0, 8'b0000_0000), 32'd3, 32'd0);
    expect_word(last_result, 32'd16, "vl kept for rs1 x0, rd x0");

    // Illegal vtypes each followed by a refused add
    foreach (bad_vt[i]) begin
      send_req(enc_vsetvli(5'd1, 5'd2, 8'b0000_0000), 32'd9, 32'd0);
      send_req(enc_vsetvli(5'd1, 5'd2, bad_vt[i]), 32'd9, 32'd0);
      expect_word(last_result, 32'd0, "vl after illegal vtype");
      send_req(enc_csr(A_VTYPE, 3'b010, 5'd0, 5'd3), 32'd0, 32'd0);
      expect_word(last_result, 32'h8000_0000, "vtype after illegal vtype");
      send_req(enc_vadd(5'd1, 5'd2, 5'd3, 1'b1), 32'd0, 32'd0);
      expect_word({31'd0, last_error}, 32'd1, "add error with vill");
    end

    // Issue port stall and back-pressure
    send_req(enc_vsetvli(5'd1, 5'd2, 8'b0001_0000), 32'd7, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b101, 5'd3, 5'd0), 32'd0, 32'd0);
    issue_ready = 1'b0;
    send_req(enc_vadd(5'd4, 5'd8, 5'd12, 1'b0), 32'd0, 32'd0);
    req_valid = 1'b1;
    req_insn  = enc_vadd(5'd5, 5'd9, 5'd13, 1'b1);
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      if (!issue_valid) begin
        $display("[FAIL] %0t: first add not on the issue port", $time);
        stim_errors++;
      end
      if (req_ready) begin
        $display("[FAIL] %0t: second add accepted while the slot was busy", $time);
        stim_errors++;
      end
      next_cycle();
    end
    issue_ready = 1'b1;
    send_req(enc_vadd(5'd5, 5'd9, 5'd13, 1'b1), 32'd0, 32'd0);

    // vstart through all six CSR forms
    send_req(enc_csr(A_VSTART, 3'b001, 5'd2, 5'd1), 32'h0000_00f0, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b010, 5'd2, 5'd1), 32'h0000_000a, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b011, 5'd2, 5'd1), 32'h0000_0082, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b101, 5'd9, 5'd1), 32'd0, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b110, 5'd6, 5'd1), 32'd0, 32'd0);
    send_req(enc_csr(A_VSTART, 3'b111, 5'd3, 5'd1), 32'd0, 32'd0);
    expect_word(last_result, 32'd15, "vstart before csrrci");
    send_req(enc_csr(A_VL, 3'b001, 5'd2, 5'd1), 32'd4, 32'd0);
    expect_word({31'd0, last_error}, 32'd1, "write to vl error");
    send_req(enc_csr(A_VTYPE, 3'b010, 5'd2, 5'd1), 32'd4, 32'd0);
    expect_word({31'd0, last_error}, 32'd1, "write to vtype error");
    send_req(enc_csr(A_VLENB, 3'b101, 5'd1, 5'd1), 32'd0, 32'd0);
    expect_word({31'd0, last_error}, 32'd1, "write to vlenb error");
    send_req(32'h0000_300b, 32'd0, 32'd0);
    expect_word({31'd0, last_error}, 32'd1, "unknown opcode error");
    send_req(enc_csr(12'h001, 3'b010, 5'd0, 5'd1), 32'd0, 32'd0);

    // Random mix with random handshake readies
    rand_ready = 1'b1;
    for (int n = 0; n < 400; n++) begin
      rnd = $random(seed);
      r2  = $random(seed);
      r3  = $random(seed);
      case (rnd[2:0])
        3'd0: send_req(enc_vsetvli(r2[12:8], r2[17:13], r2[7:0]), {23'd0, r3[8:0]}, r3);
        3'd1: send_req(enc_vsetvl(r2[12:8], r2[17:13], r2[22:18]), {23'd0, r3[8:0]},
                       {24'd0, r3[31:24]});
        3'd2, 3'd3, 3'd4: send_req(enc_vadd(r2[4:0], r2[9:5], r2[14:10], r2[15]), r3, r3);
        3'd5, 3'd6: send_req(enc_csr(csr_addrs[r2[1:0]],
                                     {r2[2], (r2[4:3] == 2'b00) ? 2'b01 : r2[4:3]},
                                     r2[5] ? 5'd0 : r2[10:6], r2[15:11]), r3, 32'd0);
        default: send_req(r2, r3, rnd);
      endcase
      if (rnd[3]) begin
        next_cycle();
      end
    end

    // Drain the issue slot
    rand_ready  = 1'b0;
    issue_ready = 1'b1;
    resp_ready  = 1'b1;
    waited      = 0;
    while ((pending != 0 || issue_valid) && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (pending != 0 || issue_valid) begin
      $display("Timeout: %0d expected issue requests never left the issue port", pending);
      stim_errors++;
    end
    next_cycle();

    $display("Errors: %0d checker, %0d stimulus, over %0d compared responses",
             chk_errors, stim_errors, chk_count);
    if (chk_errors == 0 && stim_errors == 0 && chk_count > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
/* Response and issue checker
   Reference model of vstart, vl and vtype, compares every handshake */
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
  parameter int unsigned VLEN = 256
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  logic        req_ready_i,
  input  logic [31:0] req_insn_i,
  input  logic [31:0] req_rs1_i,
  input  logic [31:0] req_rs2_i,
  input  logic        resp_valid_i,
  input  logic        resp_ready_i,
  input  logic [31:0] resp_result_i,
  input  logic        resp_error_i,
  input  logic        issue_valid_i,
  input  logic        issue_ready_i,
  input  logic [51:0] issue_bits_i,
  output int          err_count_o,
  output int          check_count_o,
  output int          pending_o
);

  // Model state, vtype kept as {vill, vma, vta, vsew, vlmul}
  logic [8:0]  m_vt;
  logic [15:0] m_vl;
  logic [15:0] m_vstart;
  logic [51:0] exp_q[$];
  logic [51:0] held_bits;
  logic        stalled;
  logic [31:0] exp_res;
  logic        exp_err;
  logic        exp_iss;
  logic [51:0] exp_bits;
  logic [51:0] head;

  initial begin
    err_count_o   = 0;
    check_count_o = 0;
    stalled       = 1'b0;
  end

  function automatic void predict(input logic [31:0] insn, input logic [31:0] rs1,
                                  input logic [31:0] rs2, output logic [31:0] res,
                                  output logic err, output logic iss,
                                  output logic [51:0] bits);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1f;
    logic [7:0]  vt;
    logic [31:0] src;
    logic        ro_ok;
    int          sew;
    int          lmul;
    int          vlmax;
    f3   = insn[14:12];
    rd   = insn[11:7];
    rs1f = insn[19:15];
    res  = 32'd0;
    err  = 1'b0;
    iss  = 1'b0;
    bits = '0;
    if (insn[6:0] == 7'h57 && f3 == 3'b111 && (!insn[31] || insn[31:25] == 7'h40)) begin
      vt   = insn[31] ? rs2[7:0] : insn[27:20];
      sew  = int'(vt[5:3]);
      lmul = int'($signed(vt[2:0]));
      if (sew > 3 || lmul == -4 || lmul + 3 < sew) begin
        m_vt = 9'h100;
        m_vl = 16'd0;
      end else begin
        m_vt  = {1'b0, vt};
        vlmax = (lmul >= 0) ? int'((VLEN << lmul) / (8 << sew)) :
                              int'((VLEN >> (-lmul)) / (8 << sew));
        if (rs1f != 5'd0) begin
          m_vl = (rs1 < 32'(vlmax)) ? rs1[15:0] : 16'(vlmax);
        end else if (rd != 5'd0) begin
          m_vl = 16'(vlmax);
        end
      end
      res = {16'd0, m_vl};
    end else if (insn[6:0] == 7'h73 && f3[1:0] != 2'b00) begin
      src   = f3[2] ? {27'd0, rs1f} : rs1;
      ro_ok = (f3[1:0] != 2'b01) && (rs1f == 5'd0);
      case (insn[31:20])
        12'h008: begin
          res = {16'd0, m_vstart};
          case (f3[1:0])
            2'b01:   m_vstart = src[15:0];
            2'b10:   m_vstart = m_vstart | src[15:0];
            default: m_vstart = m_vstart & ~src[15:0];
          endcase
        end
        12'hC20: begin
          res = {16'd0, m_vl};
          err = !ro_ok;
        end
        12'hC21: begin
          res = {m_vt[8], 23'd0, m_vt[7:0]};
          err = !ro_ok;
        end
        12'hC22: begin
          res = 32'(VLEN / 8);
          err = !ro_ok;
        end
        default: err = 1'b1;
      endcase
    end else if (insn[6:0] == 7'h57 && f3 == 3'b000 && insn[31:26] == 6'd0) begin
      // vadd.vv issues only with a legal vtype
      err = m_vt[8];
      iss = !m_vt[8];
      bits = {1'b0, insn[11:7], insn[19:15], insn[24:20], insn[25], m_vl, m_vstart,
              m_vt[5:3]};
    end else begin
      err = 1'b1;
    end
  endfunction

  // Sampled mid-cycle, inputs and outputs are settled here
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      m_vt     = 9'h100;
      m_vl     = 16'd0;
      m_vstart = 16'd0;
      stalled  = 1'b0;
    end else begin
      if (stalled && issue_bits_i != held_bits) begin
        $display("[FAIL] %0t: issue outputs changed during a stall", $time);
        err_count_o++;
      end
      if (issue_valid_i && issue_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("[FAIL] %0t: unexpected issue %h", $time, issue_bits_i);
          err_count_o++;
        end else begin
          head = exp_q.pop_front();
          if (issue_bits_i != head) begin
            $display("[FAIL] %0t: issue %h, expected %h", $time, issue_bits_i, head);
            err_count_o++;
          end
        end
      end
      stalled   = issue_valid_i && !issue_ready_i;
      held_bits = issue_bits_i;
      if (req_ready_i && !resp_ready_i) begin
        $display("[FAIL] %0t: request ready while response not ready", $time);
        err_count_o++;
      end
      if (resp_valid_i != (req_valid_i && req_ready_i)) begin
        $display("[FAIL] %0t: response valid %b without matching accept", $time,
                 resp_valid_i);
        err_count_o++;
      end
      if (req_valid_i && req_ready_i) begin
        predict(req_insn_i, req_rs1_i, req_rs2_i, exp_res, exp_err, exp_iss, exp_bits);
        check_count_o++;
        if (resp_result_i != exp_res || resp_error_i != exp_err) begin
          $display("[FAIL] %0t: insn %h gave %h/%b, expected %h/%b", $time, req_insn_i,
                   resp_result_i, resp_error_i, exp_res, exp_err);
          err_count_o++;
        end
        if (exp_iss) begin
          exp_q.push_back(exp_bits);
        end
      end
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
/* Testbench clock and reset source
   8 ns clock, active-low reset held for the first 8 cycles */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== vec_dispatcher.sv ====
/* Vector dispatcher top level
   Connects decode, execute and result stages */
`timescale 1ns/100ps
`default_nettype none

module vec_dispatcher #(
  parameter int unsigned VLEN = 256
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Request from the scalar core
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  vec_dispatch_pkg::xlen_t   req_insn_i,
  input  vec_dispatch_pkg::xlen_t   req_rs1_i,
  input  vec_dispatch_pkg::xlen_t   req_rs2_i,
  // Response to the scalar core
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i,
  output vec_dispatch_pkg::xlen_t   resp_result_o,
  output logic                      resp_error_o,
  // Backend issue port
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i,
  output vec_dispatch_pkg::vec_op_e issue_op_o,
  output logic [4:0]                issue_vd_o,
  output logic [4:0]                issue_vs1_o,
  output logic [4:0]                issue_vs2_o,
  output logic                      issue_vm_o,
  output vec_dispatch_pkg::vlen_t   issue_vl_o,
  output vec_dispatch_pkg::vlen_t   issue_vstart_o,
  output vec_dispatch_pkg::vew_e    issue_vsew_o
);

  logic                     fire;
  vec_dispatch_pkg::vlen_t  vl;
  vec_dispatch_pkg::vlen_t  vstart;
  vec_dispatch_pkg::vtype_t vtype;
  vec_dispatch_pkg::xlen_t  csr_rdata;
  logic                     exe_error;

  dispatch_if dif ();

  insn_decode u_decode (
    .insn_i (req_insn_i),
    .dif    (dif)
  );

  vcfg_exec #(
    .VLEN (VLEN)
  ) u_exec (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fire_i      (fire),
    .rs1_i       (req_rs1_i),
    .rs2_i       (req_rs2_i),
    .dif         (dif),
    .vl_o        (vl),
    .vstart_o    (vstart),
    .vtype_o     (vtype),
    .csr_rdata_o (csr_rdata),
    .exe_error_o (exe_error)
  );

  resp_issue u_resp (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .resp_ready_i   (resp_ready_i),
    .issue_ready_i  (issue_ready_i),
    .dif            (dif),
    .vl_i           (vl),
    .vstart_i       (vstart),
    .vtype_i        (vtype),
    .csr_rdata_i    (csr_rdata),
    .exe_error_i    (exe_error),
    .fire_o         (fire),
    .req_ready_o    (req_ready_o),
    .resp_valid_o   (resp_valid_o),
    .resp_result_o  (resp_result_o),
    .resp_error_o   (resp_error_o),
    .issue_valid_o  (issue_valid_o),
    .issue_op_o     (issue_op_o),
    .issue_vd_o     (issue_vd_o),
    .issue_vs1_o    (issue_vs1_o),
    .issue_vs2_o    (issue_vs2_o),
    .issue_vm_o     (issue_vm_o),
    .issue_vl_o     (issue_vl_o),
    .issue_vstart_o (issue_vstart_o),
    .issue_vsew_o   (issue_vsew_o)
  );

endmodule

`default_nettype wire

// ==== resp_issue.sv ====
/* Result stage: request acceptance, response and the registered
   backend issue slot */
`timescale 1ns/100ps
`default_nettype none

module resp_issue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  input  logic                     resp_ready_i,
  input  logic                     issue_ready_i,
  dispatch_if.res_mp               dif,
  input  vec_dispatch_pkg::vlen_t  vl_i,
  input  vec_dispatch_pkg::vlen_t  vstart_i,
  input  vec_dispatch_pkg::vtype_t vtype_i,
  input  vec_dispatch_pkg::xlen_t  csr_rdata_i,
  input  logic                     exe_error_i,
  output logic                     fire_o,
  output logic                     req_ready_o,
  output logic                     resp_valid_o,
  output vec_dispatch_pkg::xlen_t  resp_result_o,
  output logic                     resp_error_o,
  output logic                     issue_valid_o,
  output vec_dispatch_pkg::vec_op_e issue_op_o,
  output logic [4:0]               issue_vd_o,
  output logic [4:0]               issue_vs1_o,
  output logic [4:0]               issue_vs2_o,
  output logic                     issue_vm_o,
  output vec_dispatch_pkg::vlen_t  issue_vl_o,
  output vec_dispatch_pkg::vlen_t  issue_vstart_o,
  output vec_dispatch_pkg::vew_e   issue_vsew_o
);

  logic is_vadd;
  logic add_issues;
  logic slot_free;
  logic issue_load;

  assign is_vadd    = (dif.cls == vec_dispatch_pkg::CLS_VADD);
  assign add_issues = is_vadd && !vtype_i.vill;
  assign slot_free  = !issue_valid_o || issue_ready_i;

  // Only an issuing add has to wait for the slot
  assign req_ready_o  = req_valid_i && resp_ready_i && (!add_issues || slot_free);
  assign fire_o       = req_ready_o;
  assign resp_valid_o = fire_o;
  assign issue_load   = fire_o && add_issues;

  assign resp_result_o = (dif.cls inside {vec_dispatch_pkg::CLS_CSR,
                                          vec_dispatch_pkg::CLS_VSETVLI,
                                          vec_dispatch_pkg::CLS_VSETVL}) ? csr_rdata_i : '0;

  assign resp_error_o = (dif.cls == vec_dispatch_pkg::CLS_ILLEGAL) || exe_error_i ||
                        (is_vadd && vtype_i.vill);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (slot_free) begin
      issue_valid_o <= issue_load;
    end
  end

  // Payload holds while the backend stalls
  always_ff @(posedge clk_i) begin
    if (issue_load) begin
      issue_op_o     <= vec_dispatch_pkg::VADD;
      issue_vd_o     <= dif.rd_idx;
      issue_vs1_o    <= dif.rs1_idx;
      issue_vs2_o    <= dif.vs2_idx;
      issue_vm_o     <= dif.vm;
      issue_vl_o     <= vl_i;
      issue_vstart_o <= vstart_i;
      issue_vsew_o   <= vtype_i.vsew;
    end
  end

endmodule

`default_nettype wire

// ==== vcfg_exec.sv ====
/* Execute stage holding vstart, vl and vtype
   Runs vsetvl(i) and vector CSR accesses */
`timescale 1ns/100ps
`default_nettype none

module vcfg_exec #(
  parameter int unsigned VLEN = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fire_i,
  input  vec_dispatch_pkg::xlen_t  rs1_i,
  input  vec_dispatch_pkg::xlen_t  rs2_i,
  dispatch_if.exe_mp               dif,
  output vec_dispatch_pkg::vlen_t  vl_o,
  output vec_dispatch_pkg::vlen_t  vstart_o,
  output vec_dispatch_pkg::vtype_t vtype_o,
  output vec_dispatch_pkg::xlen_t  csr_rdata_o,
  output logic                     exe_error_o
);

  localparam int unsigned VLENB = VLEN / 8;

  // Reset value, also used when a new vtype is rejected
  localparam vec_dispatch_pkg::vtype_t VTYPE_ILL = '{
    vill:  1'b1,
    vma:   1'b0,
    vta:   1'b0,
    vsew:  vec_dispatch_pkg::EW8,
    vlmul: 3'sd0
  };

  vec_dispatch_pkg::vlen_t  vstart_q, vstart_d;
  vec_dispatch_pkg::vlen_t  vl_q, vl_d;
  vec_dispatch_pkg::vtype_t vtype_q, vtype_d;
  vec_dispatch_pkg::vtype_t vtype_new;
  vec_dispatch_pkg::vlen_t  vlmax;
  logic [2:0]               lmul_frac;
  logic                     is_cfg;
  logic                     vtype_bad;
  logic                     read_ok;
  vec_dispatch_pkg::xlen_t  csr_src;
  vec_dispatch_pkg::xlen_t  vtype_word;

  assign is_cfg = dif.cls inside {vec_dispatch_pkg::CLS_VSETVLI, vec_dispatch_pkg::CLS_VSETVL};

  assign vtype_new = (dif.cls == vec_dispatch_pkg::CLS_VSETVL) ?
                     vec_dispatch_pkg::vtype_t'({1'b0, rs2_i[7:0]}) : dif.imm_vtype;

  // SEW above ELEN, reserved LMUL, or fractional LMUL too small for SEW
  assign vtype_bad = (vtype_new.vsew > vec_dispatch_pkg::EW64) ||
                     (vtype_new.vlmul == 3'sb100) ||
                     (int'(vtype_new.vlmul) + $clog2(vec_dispatch_pkg::ELENB) <
                      int'(vtype_new.vsew));

  // VLMAX = LMUL * VLEN / SEW
  assign lmul_frac = 3'd0 - vtype_new.vlmul;

  always_comb begin
    vlmax = vec_dispatch_pkg::vlen_t'(VLENB) >> vtype_new.vsew;
    if (vtype_new.vlmul[2]) begin
      vlmax = vlmax >> lmul_frac;
    end else begin
      vlmax = vlmax << vtype_new.vlmul;
    end
  end

  assign csr_src = dif.use_imm ? vec_dispatch_pkg::xlen_t'(dif.uimm) : rs1_i;

  // Read-only CSRs allow only set/clear with a zero source
  assign read_ok = (dif.csr_op != vec_dispatch_pkg::CSR_RW) &&
                   (dif.use_imm ? (dif.uimm == 5'd0) : (dif.rs1_idx == 5'd0));

  assign vtype_word = {vtype_q.vill, {(vec_dispatch_pkg::XLEN - 9){1'b0}},
                       vtype_q.vma, vtype_q.vta, vtype_q.vsew, vtype_q.vlmul};

  always_comb begin
    vstart_d    = vstart_q;
    vl_d        = vl_q;
    vtype_d     = vtype_q;
    csr_rdata_o = '0;
    exe_error_o = 1'b0;
    if (is_cfg) begin
      if (vtype_bad) begin
        vtype_d = VTYPE_ILL;
        vl_d    = '0;
      end else begin
        vtype_d = vtype_new;
        // rs1 and rd both x0 keeps vl
        if (dif.rs1_idx != 5'd0) begin
          vl_d = (rs1_i > vec_dispatch_pkg::xlen_t'(vlmax)) ? vlmax :
                 vec_dispatch_pkg::vlen_t'(rs1_i);
        end else if (dif.rd_idx != 5'd0) begin
          vl_d = vlmax;
        end
      end
      // rd of vsetvl(i) receives the new vl
      csr_rdata_o = vec_dispatch_pkg::xlen_t'(vl_d);
    end else if (dif.cls == vec_dispatch_pkg::CLS_CSR) begin
      case (dif.csr_addr)
        vec_dispatch_pkg::CSR_VSTART: begin
          csr_rdata_o = vec_dispatch_pkg::xlen_t'(vstart_q);
          case (dif.csr_op)
            vec_dispatch_pkg::CSR_RW: vstart_d = vec_dispatch_pkg::vlen_t'(csr_src);
            vec_dispatch_pkg::CSR_RS: vstart_d = vstart_q | vec_dispatch_pkg::vlen_t'(csr_src);
            default: vstart_d = vstart_q & ~vec_dispatch_pkg::vlen_t'(csr_src);
          endcase
        end
        vec_dispatch_pkg::CSR_VL: begin
          csr_rdata_o = vec_dispatch_pkg::xlen_t'(vl_q);
          exe_error_o = !read_ok;
        end
        vec_dispatch_pkg::CSR_VTYPE: begin
          csr_rdata_o = vtype_word;
          exe_error_o = !read_ok;
        end
        vec_dispatch_pkg::CSR_VLENB: begin
          csr_rdata_o = vec_dispatch_pkg::xlen_t'(VLENB);
          exe_error_o = !read_ok;
        end
        default: exe_error_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vtype_q  <= VTYPE_ILL;
    end else if (fire_i) begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
    end
  end

  assign vl_o     = vl_q;
  assign vstart_o = vstart_q;
  assign vtype_o  = vtype_q;

endmodule

`default_nettype wire

// ==== insn_decode.sv ====
/* Instruction decode stage
   Classifies the incoming instruction and extracts its fields */
`timescale 1ns/100ps
`default_nettype none

module insn_decode (
  input  vec_dispatch_pkg::xlen_t insn_i,
  dispatch_if.dec_mp              dif
);

  // OP-V funct3 encodings in use
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPCFG = 3'b111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] func6;
  logic       func1;
  logic [6:0] func7;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign func6  = insn_i[31:26];
  assign func1  = insn_i[31];
  assign func7  = insn_i[31:25];

  // Register fields sit at the same place for OP-V and SYSTEM
  assign dif.rd_idx  = insn_i[11:7];
  assign dif.rs1_idx = insn_i[19:15];
  assign dif.vs2_idx = insn_i[24:20];
  assign dif.vm      = insn_i[25];

  // CSR fields
  assign dif.uimm     = insn_i[19:15];
  assign dif.csr_addr = vec_dispatch_pkg::csr_addr_e'(insn_i[31:20]);
  assign dif.csr_op   = vec_dispatch_pkg::csr_op_e'(funct3[1:0]);
  assign dif.use_imm  = funct3[2];

  // zimm[7:0] of vsetvli, vill always clear here
  assign dif.imm_vtype = vec_dispatch_pkg::vtype_t'({1'b0, insn_i[27:20]});

  always_comb begin
    dif.cls = vec_dispatch_pkg::CLS_ILLEGAL;
    case (opcode)
      vec_dispatch_pkg::OPC_VEC: begin
        case (funct3)
          F3_OPCFG: begin
            if (!func1) begin
              dif.cls = vec_dispatch_pkg::CLS_VSETVLI;
            end else if (func7 == 7'h40) begin
              dif.cls = vec_dispatch_pkg::CLS_VSETVL;
            end
          end
          F3_OPIVV: begin
            // Only vadd.vv is supported among the OPIVV ops
            if (func6 == 6'd0) begin
              dif.cls = vec_dispatch_pkg::CLS_VADD;
            end
          end
          default: ;
        endcase
      end
      vec_dispatch_pkg::OPC_SYSTEM: begin
        // funct3 000 and 100 are not CSR accesses
        if (funct3[1:0] != 2'b00) begin
          dif.cls = vec_dispatch_pkg::CLS_CSR;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== dispatch_if.sv ====
/* Decoded instruction bundle from decode to execute and result stages */
`timescale 1ns/100ps
`default_nettype none

interface dispatch_if;

  vec_dispatch_pkg::insn_class_e cls;
  vec_dispatch_pkg::csr_op_e     csr_op;
  vec_dispatch_pkg::csr_addr_e   csr_addr;
  logic [4:0]                    uimm;
  logic [4:0]                    rs1_idx;
  logic [4:0]                    rd_idx;
  logic [4:0]                    vs2_idx;
  logic                          vm;
  vec_dispatch_pkg::vtype_t      imm_vtype;
  logic                          use_imm;

  modport dec_mp (
    output cls, csr_op, csr_addr, uimm, rs1_idx, rd_idx, vs2_idx, vm, imm_vtype, use_imm
  );

  modport exe_mp (
    input cls, csr_op, csr_addr, uimm, rs1_idx, rd_idx, vs2_idx, vm, imm_vtype, use_imm
  );

  // Result stage only needs the class and the register fields
  modport res_mp (
    input cls, rd_idx, rs1_idx, vs2_idx, vm
  );

endinterface

`default_nettype wire

// ==== vec_dispatch_pkg.sv ====
/* Vector dispatcher package
   Shared widths, vtype layout, instruction classes and CSR addresses */
`default_nettype none

package vec_dispatch_pkg;

  localparam int unsigned XLEN = 32;
  typedef logic [XLEN-1:0] xlen_t;

  // Widest element supported, in bytes
  localparam int unsigned ELENB = 8;

  typedef logic [15:0] vlen_t;

  typedef enum logic [2:0] {
    EW8  = 3'd0,
    EW16 = 3'd1,
    EW32 = 3'd2,
    EW64 = 3'd3
  } vew_e;

  // Same bit order as vtype[7:0] in the CSR, vill on top
  typedef struct packed {
    logic              vill;
    logic              vma;
    logic              vta;
    vew_e              vsew;
    logic signed [2:0] vlmul;
  } vtype_t;

  typedef enum logic [2:0] {
    CLS_VSETVLI,
    CLS_VSETVL,
    CLS_VADD,
    CLS_CSR,
    CLS_ILLEGAL
  } insn_class_e;

  // Encoded as funct3[1:0] of the SYSTEM opcode
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  typedef enum logic [0:0] {
    VADD = 1'b0
  } vec_op_e;

  typedef enum logic [11:0] {
    CSR_VSTART = 12'h008,
    CSR_VL     = 12'hC20,
    CSR_VTYPE  = 12'hC21,
    CSR_VLENB  = 12'hC22
  } csr_addr_e;

  localparam logic [6:0] OPC_VEC    = 7'h57;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

endpackage

`default_nettype wire
